/* design/decode_pkg.sv */
`default_nettype none

package decode_pkg;

   localparam int XLEN           = 32;
   localparam int RF_AWIDTH      = 5;
   localparam int EXC_CODE_WIDTH = 4;

   // Number of architectural integer registers
   parameter int NUM_REGS = 32;

   typedef logic [XLEN-1:0]           xlen_t;       // Data or instruction word
   typedef logic [RF_AWIDTH-1:0]      rf_addr_t;    // Register index
   typedef logic [EXC_CODE_WIDTH-1:0] exc_code_t;   // Exception cause

   localparam exc_code_t EXC_CODE_NO_EXCEPTION      = 4'd0;
   localparam exc_code_t EXC_CODE_INSTR_ACCESS_FAULT = 4'd1;
   localparam exc_code_t EXC_CODE_ILLEGAL_INSTR      = 4'd2;

   // Major opcodes, instruction bits 6:2
   typedef enum logic [4:0] {
      OPCODE_LOAD   = 5'b00000,
      OPCODE_IMM    = 5'b00100,
      OPCODE_AUIPC  = 5'b00101,
      OPCODE_STORE  = 5'b01000,
      OPCODE_ARITH  = 5'b01100,
      OPCODE_LUI    = 5'b01101,
      OPCODE_BRANCH = 5'b11000,
      OPCODE_JALR   = 5'b11001,
      OPCODE_JAL    = 5'b11011
   } rv_opcode_e;

   typedef enum logic [3:0] {
      ALU_I_OPS_NONE,
      ALU_I_OPS_ADD,
      ALU_I_OPS_SUB,
      ALU_I_OPS_SLL,
      ALU_I_OPS_SLT,
      ALU_I_OPS_SLTU,
      ALU_I_OPS_XOR,
      ALU_I_OPS_SRL,
      ALU_I_OPS_SRA,
      ALU_I_OPS_OR,
      ALU_I_OPS_AND,
      ALU_I_OPS_COPY_OPR2   // LUI passes the immediate through
   } alu_i_ops_e;

   typedef enum logic [2:0] {
      LD_OPS_NONE,
      LD_OPS_LB,
      LD_OPS_LH,
      LD_OPS_LW,
      LD_OPS_LBU,
      LD_OPS_LHU
   } ld_ops_e;

   typedef enum logic [1:0] {
      ST_OPS_NONE,
      ST_OPS_SB,
      ST_OPS_SH,
      ST_OPS_SW
   } st_ops_e;

   typedef enum logic [2:0] {
      BR_OPS_NONE,
      BR_OPS_EQ,
      BR_OPS_NE,
      BR_OPS_LT,
      BR_OPS_GE,
      BR_OPS_LTU,
      BR_OPS_GEU
   } br_ops_e;

   typedef enum logic [1:0] {ALU_OPR1_PC, ALU_OPR1_REG} alu_opr1_sel_e;
   typedef enum logic [1:0] {ALU_OPR2_IMM, ALU_OPR2_REG} alu_opr2_sel_e;
   typedef enum logic [1:0] {ALU_CMP_OPR2_REG, ALU_CMP_OPR2_IMM} alu_cmp_opr2_sel_e;

   typedef enum logic [1:0] {
      RD_WRB_NONE,
      RD_WRB_ALU,
      RD_WRB_DMEM,
      RD_WRB_INC_PC   // Link address for JAL/JALR
   } rd_wrb_sel_e;

   typedef enum logic [2:0] {
      IMM_SEL_I,
      IMM_SEL_SHAMT,
      IMM_SEL_S,
      IMM_SEL_B,
      IMM_SEL_U,
      IMM_SEL_J
   } imm_sel_e;

endpackage : decode_pkg

`default_nettype wire

/* design/ctrl_decoder.sv */
`timescale 1ns/1ns
`default_nettype none

module ctrl_decoder (
   input  decode_pkg::xlen_t             instr_i,
   input  logic                          fetch_exc_req_i,
   input  decode_pkg::exc_code_t         fetch_exc_code_i,
   output decode_pkg::alu_i_ops_e        alu_i_ops_o,
   output decode_pkg::ld_ops_e           ld_ops_o,
   output decode_pkg::st_ops_e           st_ops_o,
   output decode_pkg::br_ops_e           branch_ops_o,
   output decode_pkg::alu_opr1_sel_e     alu_opr1_sel_o,
   output decode_pkg::alu_opr2_sel_e     alu_opr2_sel_o,
   output decode_pkg::alu_cmp_opr2_sel_e alu_cmp_opr2_sel_o,
   output decode_pkg::rd_wrb_sel_e       rd_wrb_sel_o,
   output decode_pkg::imm_sel_e          imm_sel_o,
   output logic                          rd_wr_req_o,
   output logic                          jump_req_o,
   output logic                          branch_req_o,
   output logic                          exc_req_o,
   output decode_pkg::exc_code_t         exc_code_o
);
   import decode_pkg::*;

   rv_opcode_e        opcode;
   logic [2:0]        funct3;
   logic [6:0]        funct7;
   logic              illegal_instr;
   logic              kill_ctrl;

   alu_i_ops_e        alu_i_ops;
   ld_ops_e           ld_ops;
   st_ops_e           st_ops;
   br_ops_e           branch_ops;
   alu_opr1_sel_e     alu_opr1_sel;
   alu_opr2_sel_e     alu_opr2_sel;
   alu_cmp_opr2_sel_e alu_cmp_opr2_sel;
   rd_wrb_sel_e       rd_wrb_sel;
   imm_sel_e          imm_sel;
   logic              rd_wr_req;
   logic              jump_req;
   logic              branch_req;

   assign opcode = rv_opcode_e'(instr_i[6:2]);
   assign funct3 = instr_i[14:12];
   assign funct7 = instr_i[31:25];

   always_comb begin
      alu_i_ops        = ALU_I_OPS_NONE;
      ld_ops           = LD_OPS_NONE;
      st_ops           = ST_OPS_NONE;
      branch_ops       = BR_OPS_NONE;
      alu_opr1_sel     = ALU_OPR1_PC;
      alu_opr2_sel     = ALU_OPR2_IMM;
      alu_cmp_opr2_sel = ALU_CMP_OPR2_REG;
      rd_wrb_sel       = RD_WRB_NONE;
      imm_sel          = IMM_SEL_I;
      rd_wr_req        = 1'b0;
      jump_req         = 1'b0;
      branch_req       = 1'b0;
      illegal_instr    = (instr_i[1:0] != 2'b11);   // Compressed encodings not supported

      case (opcode)
         OPCODE_ARITH : begin
            rd_wrb_sel   = RD_WRB_ALU;
            alu_opr1_sel = ALU_OPR1_REG;
            alu_opr2_sel = ALU_OPR2_REG;
            rd_wr_req    = 1'b1;
            case (funct7)
               7'b0000000 : begin
                  case (funct3)
                     3'b000 : alu_i_ops = ALU_I_OPS_ADD;
                     3'b001 : alu_i_ops = ALU_I_OPS_SLL;
                     3'b010 : alu_i_ops = ALU_I_OPS_SLT;
                     3'b011 : alu_i_ops = ALU_I_OPS_SLTU;
                     3'b100 : alu_i_ops = ALU_I_OPS_XOR;
                     3'b101 : alu_i_ops = ALU_I_OPS_SRL;
                     3'b110 : alu_i_ops = ALU_I_OPS_OR;
                     3'b111 : alu_i_ops = ALU_I_OPS_AND;
                  endcase
               end
               7'b0100000 : begin
                  case (funct3)
                     3'b000  : alu_i_ops = ALU_I_OPS_SUB;
                     3'b101  : alu_i_ops = ALU_I_OPS_SRA;
                     default : illegal_instr = 1'b1;
                  endcase
               end
               default : illegal_instr = 1'b1;   // Includes M extension
            endcase
         end

         OPCODE_IMM : begin
            rd_wrb_sel       = RD_WRB_ALU;
            alu_opr1_sel     = ALU_OPR1_REG;
            alu_cmp_opr2_sel = ALU_CMP_OPR2_IMM;   // SLTI/SLTIU compare against imm
            rd_wr_req        = 1'b1;
            case (funct3)
               3'b000 : alu_i_ops = ALU_I_OPS_ADD;
               3'b010 : alu_i_ops = ALU_I_OPS_SLT;
               3'b011 : alu_i_ops = ALU_I_OPS_SLTU;
               3'b100 : alu_i_ops = ALU_I_OPS_XOR;
               3'b110 : alu_i_ops = ALU_I_OPS_OR;
               3'b111 : alu_i_ops = ALU_I_OPS_AND;
               3'b001 : begin
                  imm_sel       = IMM_SEL_SHAMT;
                  alu_i_ops     = ALU_I_OPS_SLL;
                  illegal_instr = illegal_instr | (funct7 != 7'b0000000);
               end
               3'b101 : begin
                  imm_sel = IMM_SEL_SHAMT;
                  case (funct7)
                     7'b0000000 : alu_i_ops = ALU_I_OPS_SRL;
                     7'b0100000 : alu_i_ops = ALU_I_OPS_SRA;
                     default    : illegal_instr = 1'b1;
                  endcase
               end
            endcase
         end

         OPCODE_AUIPC : begin
            rd_wrb_sel = RD_WRB_ALU;
            alu_i_ops  = ALU_I_OPS_ADD;   // pc + upper imm
            imm_sel    = IMM_SEL_U;
            rd_wr_req  = 1'b1;
         end

         OPCODE_LUI : begin
            rd_wrb_sel = RD_WRB_ALU;
            alu_i_ops  = ALU_I_OPS_COPY_OPR2;
            imm_sel    = IMM_SEL_U;
            rd_wr_req  = 1'b1;
         end

         OPCODE_LOAD : begin
            rd_wrb_sel   = RD_WRB_DMEM;
            alu_opr1_sel = ALU_OPR1_REG;
            alu_i_ops    = ALU_I_OPS_ADD;   // Address generation
            rd_wr_req    = 1'b1;
            case (funct3)
               3'b000  : ld_ops = LD_OPS_LB;
               3'b001  : ld_ops = LD_OPS_LH;
               3'b010  : ld_ops = LD_OPS_LW;
               3'b100  : ld_ops = LD_OPS_LBU;
               3'b101  : ld_ops = LD_OPS_LHU;
               default : illegal_instr = 1'b1;
            endcase
         end

         OPCODE_STORE : begin
            alu_opr1_sel = ALU_OPR1_REG;
            alu_i_ops    = ALU_I_OPS_ADD;
            imm_sel      = IMM_SEL_S;
            case (funct3)
               3'b000  : st_ops = ST_OPS_SB;
               3'b001  : st_ops = ST_OPS_SH;
               3'b010  : st_ops = ST_OPS_SW;
               default : illegal_instr = 1'b1;
            endcase
         end

         OPCODE_BRANCH : begin
            alu_i_ops  = ALU_I_OPS_ADD;   // Target is pc + offset
            imm_sel    = IMM_SEL_B;
            branch_req = 1'b1;
            case (funct3)
               3'b000  : branch_ops = BR_OPS_EQ;
               3'b001  : branch_ops = BR_OPS_NE;
               3'b100  : branch_ops = BR_OPS_LT;
               3'b101  : branch_ops = BR_OPS_GE;
               3'b110  : branch_ops = BR_OPS_LTU;
               3'b111  : branch_ops = BR_OPS_GEU;
               default : illegal_instr = 1'b1;
            endcase
         end

         OPCODE_JALR : begin
            rd_wrb_sel    = RD_WRB_INC_PC;
            alu_opr1_sel  = ALU_OPR1_REG;
            alu_i_ops     = ALU_I_OPS_ADD;
            rd_wr_req     = 1'b1;
            jump_req      = 1'b1;
            illegal_instr = illegal_instr | (funct3 != 3'b000);
         end

         OPCODE_JAL : begin
            rd_wrb_sel = RD_WRB_INC_PC;
            alu_i_ops  = ALU_I_OPS_ADD;
            imm_sel    = IMM_SEL_J;
            rd_wr_req  = 1'b1;
            jump_req   = 1'b1;
         end

         default : illegal_instr = 1'b1;   // Fence, system, AMO and undefined
      endcase
   end

   // Fetch fault wins over any decode result
   assign kill_ctrl = fetch_exc_req_i | illegal_instr;

   assign alu_i_ops_o        = kill_ctrl ? ALU_I_OPS_NONE : alu_i_ops;
   assign ld_ops_o           = kill_ctrl ? LD_OPS_NONE : ld_ops;
   assign st_ops_o           = kill_ctrl ? ST_OPS_NONE : st_ops;
   assign branch_ops_o       = kill_ctrl ? BR_OPS_NONE : branch_ops;
   assign alu_opr1_sel_o     = kill_ctrl ? ALU_OPR1_PC : alu_opr1_sel;
   assign alu_opr2_sel_o     = kill_ctrl ? ALU_OPR2_IMM : alu_opr2_sel;
   assign alu_cmp_opr2_sel_o = kill_ctrl ? ALU_CMP_OPR2_REG : alu_cmp_opr2_sel;
   assign rd_wrb_sel_o       = kill_ctrl ? RD_WRB_NONE : rd_wrb_sel;
   assign imm_sel_o          = kill_ctrl ? IMM_SEL_I : imm_sel;
   assign rd_wr_req_o        = rd_wr_req & ~kill_ctrl;
   assign jump_req_o         = jump_req & ~kill_ctrl;
   assign branch_req_o       = branch_req & ~kill_ctrl;

   assign exc_req_o  = kill_ctrl;
   assign exc_code_o = fetch_exc_req_i ? fetch_exc_code_i :
                       illegal_instr   ? EXC_CODE_ILLEGAL_INSTR :
                                         EXC_CODE_NO_EXCEPTION;

endmodule : ctrl_decoder

`default_nettype wire

/* design/imm_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module imm_gen (
   input  decode_pkg::xlen_t    instr_i,
   input  decode_pkg::imm_sel_e imm_sel_i,
   output decode_pkg::xlen_t    imm_o
);
   import decode_pkg::*;

   logic sign;

   assign sign = instr_i[31];

   always_comb begin
      case (imm_sel_i)
         IMM_SEL_SHAMT : begin
            imm_o = {27'b0, instr_i[24:20]};   // Zero extended shift amount
         end
         IMM_SEL_S : begin
            imm_o = {{20{sign}}, instr_i[31:25], instr_i[11:7]};
         end
         IMM_SEL_B : begin
            imm_o = {{19{sign}}, instr_i[31], instr_i[7], instr_i[30:25],
                     instr_i[11:8], 1'b0};
         end
         IMM_SEL_U : begin
            imm_o = {instr_i[31:12], 12'b0};
         end
         IMM_SEL_J : begin
            imm_o = {{11{sign}}, instr_i[31], instr_i[19:12], instr_i[20],
                     instr_i[30:21], 1'b0};
         end
         default : begin
            imm_o = {{20{sign}}, instr_i[31:20]};   // I format
         end
      endcase
   end

endmodule : imm_gen

`default_nettype wire

/* design/reg_file.sv */
`timescale 1ns/1ns
`default_nettype none

module reg_file (
   input  logic                 clk,
   input  logic                 rst_i,
   input  decode_pkg::rf_addr_t rs1_addr_i,
   input  decode_pkg::rf_addr_t rs2_addr_i,
   input  logic                 rd_wr_req_i,
   input  decode_pkg::rf_addr_t rd_addr_i,
   input  decode_pkg::xlen_t    rd_data_i,
   output decode_pkg::xlen_t    rs1_data_o,
   output decode_pkg::xlen_t    rs2_data_o
);
   import decode_pkg::*;

   xlen_t regs [NUM_REGS];

   always_ff @(posedge clk) begin
      if (rst_i) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (rd_wr_req_i && (rd_addr_i != '0)) begin   // x0 stays zero
         regs[rd_addr_i] <= rd_data_i;
      end
   end

   // Reads see only what was written on earlier edges
   assign rs1_data_o = regs[rs1_addr_i];
   assign rs2_data_o = regs[rs2_addr_i];

   a_rd_addr_known : assert property (
      @(posedge clk) disable iff (rst_i)
      rd_wr_req_i |-> !$isunknown(rd_addr_i)
   ) else $error("reg_file: write strobe with unknown rd address");

   // Entry 0 holds its reset value through every later write
   a_x0_reads_zero : assert property (
      @(posedge clk) disable iff (rst_i)
      ((rs1_addr_i == '0) -> (rs1_data_o == '0)) &&
      ((rs2_addr_i == '0) -> (rs2_data_o == '0))
   ) else $error("reg_file: x0 read returned nonzero");

endmodule : reg_file

`default_nettype wire

/* design/decode_top.sv */
`timescale 1ns/1ns
`default_nettype none

module decode_top (
   input  logic                          clk,
   input  logic                          rst_i,
   // Fetch side
   input  decode_pkg::xlen_t             instr_i,
   input  logic                          fetch_exc_req_i,
   input  decode_pkg::exc_code_t         fetch_exc_code_i,
   // Writeback side
   input  logic                          wrb_rd_wr_req_i,
   input  decode_pkg::rf_addr_t          wrb_rd_addr_i,
   input  decode_pkg::xlen_t             wrb_rd_data_i,
   // Toward execute
   output decode_pkg::alu_i_ops_e        alu_i_ops_o,
   output decode_pkg::ld_ops_e           ld_ops_o,
   output decode_pkg::st_ops_e           st_ops_o,
   output decode_pkg::br_ops_e           branch_ops_o,
   output decode_pkg::alu_opr1_sel_e     alu_opr1_sel_o,
   output decode_pkg::alu_opr2_sel_e     alu_opr2_sel_o,
   output decode_pkg::alu_cmp_opr2_sel_e alu_cmp_opr2_sel_o,
   output decode_pkg::rd_wrb_sel_e       rd_wrb_sel_o,
   output logic                          rd_wr_req_o,
   output logic                          jump_req_o,
   output logic                          branch_req_o,
   output logic                          exc_req_o,
   output decode_pkg::exc_code_t         exc_code_o,
   output decode_pkg::xlen_t             imm_o,
   output decode_pkg::xlen_t             rs1_data_o,
   output decode_pkg::xlen_t             rs2_data_o
);
   import decode_pkg::*;

   rf_addr_t rs1_addr;
   rf_addr_t rs2_addr;
   imm_sel_e imm_sel;

   assign rs1_addr = instr_i[19:15];
   assign rs2_addr = instr_i[24:20];

   ctrl_decoder u_ctrl_decoder (
      .instr_i            (instr_i),
      .fetch_exc_req_i    (fetch_exc_req_i),
      .fetch_exc_code_i   (fetch_exc_code_i),
      .alu_i_ops_o        (alu_i_ops_o),
      .ld_ops_o           (ld_ops_o),
      .st_ops_o           (st_ops_o),
      .branch_ops_o       (branch_ops_o),
      .alu_opr1_sel_o     (alu_opr1_sel_o),
      .alu_opr2_sel_o     (alu_opr2_sel_o),
      .alu_cmp_opr2_sel_o (alu_cmp_opr2_sel_o),
      .rd_wrb_sel_o       (rd_wrb_sel_o),
      .imm_sel_o          (imm_sel),
      .rd_wr_req_o        (rd_wr_req_o),
      .jump_req_o         (jump_req_o),
      .branch_req_o       (branch_req_o),
      .exc_req_o          (exc_req_o),
      .exc_code_o         (exc_code_o)
   );

   imm_gen u_imm_gen (
      .instr_i   (instr_i),
      .imm_sel_i (imm_sel),
      .imm_o     (imm_o)
   );

   reg_file u_reg_file (
      .clk         (clk),
      .rst_i       (rst_i),
      .rs1_addr_i  (rs1_addr),
      .rs2_addr_i  (rs2_addr),
      .rd_wr_req_i (wrb_rd_wr_req_i),
      .rd_addr_i   (wrb_rd_addr_i),
      .rd_data_i   (wrb_rd_data_i),
      .rs1_data_o  (rs1_data_o),
      .rs2_data_o  (rs2_data_o)
   );

endmodule : decode_top

`default_nettype wire

/* tb/decode_vectors.svh */
// Register ALU
add_vec(32'h003100B3, ALU_I_OPS_ADD, LD_OPS_NONE, ST_OPS_NONE, BR_OPS_NONE,
        ALU_OPR1_REG, ALU_OPR2_REG, ALU_CMP_OPR2_REG, RD_WRB_ALU, 3'b100, 32'h00000003);
add_vec(32'h003130B3, ALU_I_OPS_SLTU, LD_OPS_NONE, ST_OPS_NONE, BR_OPS_NONE,
        ALU_OPR1_REG, ALU_OPR2_REG, ALU_CMP_OPR2_REG, RD_WRB_ALU, 3'b100, 32'h00000003);
add_vec(32'h403100B3, ALU_I_OPS_SUB, LD_OPS_NONE, ST_OPS_NONE, BR_OPS_NONE,
        ALU_OPR1_REG, ALU_OPR2_REG, ALU_CMP_OPR2_REG, RD_WRB_ALU, 3'b100, 32'h00000403);
add_vec(32'h403150B3, ALU_I_OPS_SRA, LD_OPS_NONE, ST_OPS_NONE, BR_OPS_NONE,
        ALU_OPR1_REG, ALU_OPR2_REG, ALU_CMP_OPR2_REG, RD_WRB_ALU, 3'b100, 32'h00000403);
// Immediate ALU and shifts
add_vec(32'hFFF10093, ALU_I_OPS_ADD, LD_OPS_NONE, ST_OPS_NONE, BR_OPS_NONE,
        ALU_OPR1_REG, ALU_OPR2_IMM, ALU_CMP_OPR2_IMM, RD_WRB_ALU, 3'b100, 32'hFFFFFFFF);
add_vec(32'h7FF13093, ALU_I_OPS_SLTU, LD_OPS_NONE, ST_OPS_NONE, BR_OPS_NONE,
        ALU_OPR1_REG, ALU_OPR2_IMM, ALU_CMP_OPR2_IMM, RD_WRB_ALU, 3'b100, 32'h000007FF);
add_vec(32'h01F11093, ALU_I_OPS_SLL, LD_OPS_NONE, ST_OPS_NONE, BR_OPS_NONE,
        ALU_OPR1_REG, ALU_OPR2_IMM, ALU_CMP_OPR2_IMM, RD_WRB_ALU, 3'b100, 32'h0000001F);
add_vec(32'h40715093, ALU_I_OPS_SRA, LD_OPS_NONE, ST_OPS_NONE, BR_OPS_NONE,
        ALU_OPR1_REG, ALU_OPR2_IMM, ALU_CMP_OPR2_IMM, RD_WRB_ALU, 3'b100, 32'h00000007);
// LUI and AUIPC
add_vec(32'hABCDE0B7, ALU_I_OPS_COPY_OPR2, LD_OPS_NONE, ST_OPS_NONE, BR_OPS_NONE,
        ALU_OPR1_PC, ALU_OPR2_IMM, ALU_CMP_OPR2_REG, RD_WRB_ALU, 3'b100, 32'hABCDE000);
add_vec(32'h12345097, ALU_I_OPS_ADD, LD_OPS_NONE, ST_OPS_NONE, BR_OPS_NONE,
        ALU_OPR1_PC, ALU_OPR2_IMM, ALU_CMP_OPR2_REG, RD_WRB_ALU, 3'b100, 32'h12345000);
// Loads and stores
add_vec(32'hFFC12083, ALU_I_OPS_ADD, LD_OPS_LW, ST_OPS_NONE, BR_OPS_NONE,
        ALU_OPR1_REG, ALU_OPR2_IMM, ALU_CMP_OPR2_REG, RD_WRB_DMEM, 3'b100, 32'hFFFFFFFC);
add_vec(32'h01014083, ALU_I_OPS_ADD, LD_OPS_LBU, ST_OPS_NONE, BR_OPS_NONE,
        ALU_OPR1_REG, ALU_OPR2_IMM, ALU_CMP_OPR2_REG, RD_WRB_DMEM, 3'b100, 32'h00000010);
add_vec(32'hFE312C23, ALU_I_OPS_ADD, LD_OPS_NONE, ST_OPS_SW, BR_OPS_NONE,
        ALU_OPR1_REG, ALU_OPR2_IMM, ALU_CMP_OPR2_REG, RD_WRB_NONE, 3'b000, 32'hFFFFFFF8);
add_vec(32'h023102A3, ALU_I_OPS_ADD, LD_OPS_NONE, ST_OPS_SB, BR_OPS_NONE,
        ALU_OPR1_REG, ALU_OPR2_IMM, ALU_CMP_OPR2_REG, RD_WRB_NONE, 3'b000, 32'h00000025);
// Branches and jumps
add_vec(32'h00310863, ALU_I_OPS_ADD, LD_OPS_NONE, ST_OPS_NONE, BR_OPS_EQ,
        ALU_OPR1_PC, ALU_OPR2_IMM, ALU_CMP_OPR2_REG, RD_WRB_NONE, 3'b001, 32'h00000010);
add_vec(32'hFE317FE3, ALU_I_OPS_ADD, LD_OPS_NONE, ST_OPS_NONE, BR_OPS_GEU,
        ALU_OPR1_PC, ALU_OPR2_IMM, ALU_CMP_OPR2_REG, RD_WRB_NONE, 3'b001, 32'hFFFFFFFE);
add_vec(32'hFFDFF0EF, ALU_I_OPS_ADD, LD_OPS_NONE, ST_OPS_NONE, BR_OPS_NONE,
        ALU_OPR1_PC, ALU_OPR2_IMM, ALU_CMP_OPR2_REG, RD_WRB_INC_PC, 3'b110, 32'hFFFFFFFC);
add_vec(32'h008100E7, ALU_I_OPS_ADD, LD_OPS_NONE, ST_OPS_NONE, BR_OPS_NONE,
        ALU_OPR1_REG, ALU_OPR2_IMM, ALU_CMP_OPR2_REG, RD_WRB_INC_PC, 3'b110, 32'h00000008);
// Illegal encodings
add_exc(32'h00000000, 1'b0, EXC_CODE_ILLEGAL_INSTR, 32'h00000000);   // Low bits not 11
add_exc(32'h0000005B, 1'b0, EXC_CODE_ILLEGAL_INSTR, 32'h00000000);   // Reserved opcode
add_exc(32'h023100B3, 1'b0, EXC_CODE_ILLEGAL_INSTR, 32'h00000023);   // MUL
add_exc(32'h003120AF, 1'b0, EXC_CODE_ILLEGAL_INSTR, 32'h00000003);   // AMOADD.W
add_exc(32'h00000073, 1'b0, EXC_CODE_ILLEGAL_INSTR, 32'h00000000);   // ECALL
add_exc(32'h0FF0000F, 1'b0, EXC_CODE_ILLEGAL_INSTR, 32'h000000FF);   // FENCE
add_exc(32'h00013083, 1'b0, EXC_CODE_ILLEGAL_INSTR, 32'h00000000);   // Load funct3 011
add_exc(32'h00313023, 1'b0, EXC_CODE_ILLEGAL_INSTR, 32'h00000003);   // Store funct3 011
add_exc(32'h00312063, 1'b0, EXC_CODE_ILLEGAL_INSTR, 32'h00000003);   // Branch funct3 010
add_exc(32'h403110B3, 1'b0, EXC_CODE_ILLEGAL_INSTR, 32'h00000403);   // R-type funct7 on SLL
add_exc(32'h40111093, 1'b0, EXC_CODE_ILLEGAL_INSTR, 32'h00000401);   // SLLI with funct7 0100000
// Fetch faults on legal and illegal words
add_exc(32'h003100B3, 1'b1, EXC_CODE_INSTR_ACCESS_FAULT, 32'h00000003);
add_exc(32'hFE312C23, 1'b1, 4'hC, 32'hFFFFFFE3);
add_exc(32'h023100B3, 1'b1, EXC_CODE_INSTR_ACCESS_FAULT, 32'h00000023);

/* tb/decode_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module decode_tb;
   import decode_pkg::*;

   localparam int RESET_CYCLES = 5;
   localparam int ZERO_READS   = 4;
   localparam int NUM_WRITES   = 24;
   localparam int NUM_READS    = 24;

   typedef struct packed {
      xlen_t             instr;
      logic              fexc;
      exc_code_t         fcode;
      alu_i_ops_e        alu;
      ld_ops_e           ld;
      st_ops_e           st;
      br_ops_e           br;
      alu_opr1_sel_e     o1;
      alu_opr2_sel_e     o2;
      alu_cmp_opr2_sel_e cmp;
      rd_wrb_sel_e       wrb;
      logic [2:0]        req;   // rd_wr, jump, branch
      logic              exc;
      exc_code_t         code;
      xlen_t             imm;
   } vec_t;

   logic              clk;
   logic              rst_i;
   xlen_t             instr_i;
   logic              fetch_exc_req_i;
   exc_code_t         fetch_exc_code_i;
   logic              wrb_rd_wr_req_i;
   rf_addr_t          wrb_rd_addr_i;
   xlen_t             wrb_rd_data_i;
   alu_i_ops_e        alu_i_ops_o;
   ld_ops_e           ld_ops_o;
   st_ops_e           st_ops_o;
   br_ops_e           branch_ops_o;
   alu_opr1_sel_e     alu_opr1_sel_o;
   alu_opr2_sel_e     alu_opr2_sel_o;
   alu_cmp_opr2_sel_e alu_cmp_opr2_sel_o;
   rd_wrb_sel_e       rd_wrb_sel_o;
   logic              rd_wr_req_o;
   logic              jump_req_o;
   logic              branch_req_o;
   logic              exc_req_o;
   exc_code_t         exc_code_o;
   xlen_t             imm_o;
   xlen_t             rs1_data_o;
   xlen_t             rs2_data_o;

   vec_t        vecs [$];
   xlen_t       shadow [NUM_REGS];   // Last value written per register
   logic [31:0] lfsr;
   int          errors      = 0;
   int          checks      = 0;
   int          cycle_count = 0;
   int          cycle_limit = 1000;

   decode_top dut (
      .clk                (clk),
      .rst_i              (rst_i),
      .instr_i            (instr_i),
      .fetch_exc_req_i    (fetch_exc_req_i),
      .fetch_exc_code_i   (fetch_exc_code_i),
      .wrb_rd_wr_req_i    (wrb_rd_wr_req_i),
      .wrb_rd_addr_i      (wrb_rd_addr_i),
      .wrb_rd_data_i      (wrb_rd_data_i),
      .alu_i_ops_o        (alu_i_ops_o),
      .ld_ops_o           (ld_ops_o),
      .st_ops_o           (st_ops_o),
      .branch_ops_o       (branch_ops_o),
      .alu_opr1_sel_o     (alu_opr1_sel_o),
      .alu_opr2_sel_o     (alu_opr2_sel_o),
      .alu_cmp_opr2_sel_o (alu_cmp_opr2_sel_o),
      .rd_wrb_sel_o       (rd_wrb_sel_o),
      .rd_wr_req_o        (rd_wr_req_o),
      .jump_req_o         (jump_req_o),
      .branch_req_o       (branch_req_o),
      .exc_req_o          (exc_req_o),
      .exc_code_o         (exc_code_o),
      .imm_o              (imm_o),
      .rs1_data_o         (rs1_data_o),
      .rs2_data_o         (rs2_data_o)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   always @(posedge clk) begin
      cycle_count = cycle_count + 1;
      if (cycle_count > cycle_limit) begin
         $display("timeout: the run did not finish within %0d cycles", cycle_limit);
         $display("** FAIL **");
         $finish;
      end
   end

   // Taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic take_bits(input int n, output logic [31:0] val);
      val = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);
         val  = {val[30:0], lfsr[0]};
      end
   endtask

   task automatic add_vec(input xlen_t instr, input alu_i_ops_e alu, input ld_ops_e ld,
                          input st_ops_e st, input br_ops_e br, input alu_opr1_sel_e o1,
                          input alu_opr2_sel_e o2, input alu_cmp_opr2_sel_e cmp,
                          input rd_wrb_sel_e wrb, input logic [2:0] req, input xlen_t imm);
      vec_t v;
      v = '{instr, 1'b0, EXC_CODE_NO_EXCEPTION, alu, ld, st, br, o1, o2, cmp, wrb, req,
            1'b0, EXC_CODE_NO_EXCEPTION, imm};
      vecs.push_back(v);
   endtask

   // Every control at its default
   task automatic add_exc(input xlen_t instr, input logic fexc, input exc_code_t code,
                          input xlen_t imm);
      vec_t v;
      v = '{instr, fexc, fexc ? code : 4'd0, ALU_I_OPS_NONE, LD_OPS_NONE, ST_OPS_NONE,
            BR_OPS_NONE, ALU_OPR1_PC, ALU_OPR2_IMM, ALU_CMP_OPR2_REG, RD_WRB_NONE, 3'b000,
            1'b1, code, imm};
      vecs.push_back(v);
   endtask

   task automatic load_table;
      `include "decode_vectors.svh"
   endtask

   task automatic check_field(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("error at %0t: instr %h, %s is %h, expected %h",
                  $time, instr_i, what, got, exp);
      end
   endtask

   task automatic write_reg(input rf_addr_t addr, input xlen_t data);
      @(negedge clk);
      wrb_rd_wr_req_i = 1'b1;
      wrb_rd_addr_i   = addr;
      wrb_rd_data_i   = data;
      if (addr != '0) begin
         shadow[addr] = data;   // x0 ignores writes
      end
   endtask

   // ADD x1, a1, a2 puts the two indices on the read ports
   task automatic read_regs(input rf_addr_t a1, input rf_addr_t a2);
      @(negedge clk);
      instr_i         = {7'b0, a2, a1, 3'b000, 5'd1, 7'b0110011};
      fetch_exc_req_i = 1'b0;
      #1;
      check_field("rs1_data_o", rs1_data_o, shadow[a1]);
      check_field("rs2_data_o", rs2_data_o, shadow[a2]);
   endtask

   task automatic apply_row(input vec_t v);
      @(negedge clk);
      instr_i          = v.instr;
      fetch_exc_req_i  = v.fexc;
      fetch_exc_code_i = v.fcode;
      #1;
      check_field("alu_i_ops_o", 32'(alu_i_ops_o), 32'(v.alu));
      check_field("ld_ops_o", 32'(ld_ops_o), 32'(v.ld));
      check_field("st_ops_o", 32'(st_ops_o), 32'(v.st));
      check_field("branch_ops_o", 32'(branch_ops_o), 32'(v.br));
      check_field("alu_opr1_sel_o", 32'(alu_opr1_sel_o), 32'(v.o1));
      check_field("alu_opr2_sel_o", 32'(alu_opr2_sel_o), 32'(v.o2));
      check_field("alu_cmp_opr2_sel_o", 32'(alu_cmp_opr2_sel_o), 32'(v.cmp));
      check_field("rd_wrb_sel_o", 32'(rd_wrb_sel_o), 32'(v.wrb));
      check_field("rd_wr/jump/branch req", 32'({rd_wr_req_o, jump_req_o, branch_req_o}),
                  32'(v.req));
      check_field("exc_req_o", 32'(exc_req_o), 32'(v.exc));
      check_field("exc_code_o", 32'(exc_code_o), 32'(v.code));
      check_field("imm_o", imm_o, v.imm);
   endtask

   initial begin
      logic [31:0] bits_a;
      logic [31:0] bits_b;

      rst_i            = 1'b1;
      instr_i          = 32'h00000013;   // NOP
      fetch_exc_req_i  = 1'b0;
      fetch_exc_code_i = EXC_CODE_NO_EXCEPTION;
      wrb_rd_wr_req_i  = 1'b0;
      wrb_rd_addr_i    = '0;
      wrb_rd_data_i    = '0;
      lfsr             = 32'h2f1f;
      for (int i = 0; i < NUM_REGS; i++) begin
         shadow[i] = '0;
      end
      load_table();
      cycle_limit = RESET_CYCLES + NUM_WRITES + 2 + vecs.size() + ZERO_READS + NUM_READS
                    + 1 + 20;

      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      rst_i = 1'b0;

      for (int i = 0; i < ZERO_READS; i++) begin
         take_bits(5, bits_a);
         take_bits(5, bits_b);
         read_regs(bits_a[4:0], bits_b[4:0]);
      end

      take_bits(32, bits_a);
      write_reg(5'd0, bits_a);
      for (int i = 0; i < NUM_WRITES; i++) begin
         take_bits(5, bits_a);
         take_bits(32, bits_b);
         write_reg(bits_a[4:0], bits_b);
      end
      @(negedge clk);
      wrb_rd_wr_req_i = 1'b0;

      read_regs(5'd0, 5'd0);
      for (int i = 0; i < NUM_READS; i++) begin
         take_bits(5, bits_a);
         take_bits(5, bits_b);
         read_regs(bits_a[4:0], bits_b[4:0]);
      end

      for (int r = 0; r < vecs.size(); r++) begin
         apply_row(vecs[r]);
      end

      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule : decode_tb

`default_nettype wire

/* compile.f */
+incdir+tb
design/decode_pkg.sv
design/ctrl_decoder.sv
design/imm_gen.sv
design/reg_file.sv
design/decode_top.sv
tb/decode_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module decode_tb \
   -Mdir obj_dir -o decode_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

out=$(./obj_dir/decode_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -qF '** PASS **'; then
   exit 0
fi
exit 1
